//--- src.f
+incdir+design
design/uvReconPkg.sv
design/uvForwardTransform.sv
design/uvQuantizer.sv
design/uvInverseTransform.sv
design/uvReconstruct.sv
testbench/uvReconstruct_asserts.sv
testbench/uvReconstructTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module uvReconstructTb -f src.f -o uvReconstructSim

out=$(./obj_dir/uvReconstructSim)
echo "$out"

if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1

//--- testbench/uvReconstructTb.sv
// Chroma reconstruction testbench
`timescale 1ns/1ps
`default_nettype none

`include "uvRecon_settings.svh"

module uvReconstructTb;

    import uvReconPkg::*;

    localparam int NUM_ZERO   = 20;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_DEAD   = 40;
    localparam int NUM_BURST  = 120;
    localparam int TOTAL_JOBS = NUM_ZERO + NUM_RANDOM + NUM_DEAD + NUM_BURST;
    localparam int MAX_CYCLES = TOTAL_JOBS * 20 + 100;

    typedef struct packed {
        pixBlock_t  recon;
        coefBlock_t levels;
        logic       nz;
        pixBlock_t  pred;
        logic       quiet;
        logic       clamped;
    } expect_t;

    logic         clk;
    logic         rstN;
    logic         start;
    pixBlock_t    src;
    pixBlock_t    pred;
    quantParams_t qp;
    logic         done;
    pixBlock_t    recon;
    coefBlock_t   levels;
    logic         nz;

    logic [31:0]  rngState = 32'h8c0ab6d1;
    expect_t      expQ [$];
    int           startCycleQ [$];
    int           negCycle = 0;
    int           errors = 0;
    int           jobsChecked = 0;
    int           testsRun = 0;
    logic         markQuiet = 1'b0;
    logic         markClamped = 1'b0;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    uvReconstruct i_uvReconstruct (
        .clk      (clk),
        .rstN_i   (rstN),
        .start_i  (start),
        .src_i    (src),
        .pred_i   (pred),
        .qp_i     (qp),
        .done_o   (done),
        .recon_o  (recon),
        .levels_o (levels),
        .nz_o     (nz)
    );

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic pixBlock_t randBlock();
        pixBlock_t b;
        for (int k = 0; k < 4; k++) begin
            b[4*k +: 4] = nextRand();
        end
        return b;
    endfunction

    // VP8 style table entry with q from 4 to 127
    function automatic quantSet_t typicalSet(input logic isDc);
        quantSet_t s;
        int q;
        q         = 4 + int'(nextRand() % 124);
        s.q       = 16'(q);
        s.iq      = 16'((1 << `UV_QFIX) / q);
        s.bias    = (isDc ? 32'd96 : 32'd110) << 9;
        s.zthresh = ((32'd1 << `UV_QFIX) - 32'd1 - s.bias) / 32'(s.iq);
        return s;
    endfunction

    function automatic quantParams_t randParams();
        quantParams_t p;
        p.dc = typicalSet(1'b1);
        p.ac = typicalSet(1'b0);
        return p;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    function automatic coefBlock_t forwardModel(input pixBlock_t s, input pixBlock_t p);
        int d [16];
        int t [16];
        int a0;
        int a1;
        int a2;
        int a3;
        coefBlock_t out;
        for (int k = 0; k < 16; k++) begin
            d[k] = int'(s[k]) - int'(p[k]);
        end
        for (int r = 0; r < 4; r++) begin
            a0 = d[4*r] + d[4*r+3];
            a1 = d[4*r+1] + d[4*r+2];
            a2 = d[4*r+1] - d[4*r+2];
            a3 = d[4*r] - d[4*r+3];
            t[4*r]   = (a0 + a1) * 8;
            t[4*r+1] = (a2 * 2217 + a3 * 5352 + 1812) >>> 9;
            t[4*r+2] = (a0 - a1) * 8;
            t[4*r+3] = (a3 * 2217 - a2 * 5352 + 937) >>> 9;
        end
        for (int c = 0; c < 4; c++) begin
            a0 = t[c] + t[12+c];
            a1 = t[4+c] + t[8+c];
            a2 = t[4+c] - t[8+c];
            a3 = t[c] - t[12+c];
            out[c]    = 16'((a0 + a1 + 7) >>> 4);
            out[4+c]  = 16'(((a2 * 2217 + a3 * 5352 + 12000) >>> 16) + ((a3 != 0) ? 1 : 0));
            out[8+c]  = 16'((a0 - a1 + 7) >>> 4);
            out[12+c] = 16'((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
        end
        return out;
    endfunction

    function automatic void quantModel(input coefBlock_t coef, input quantParams_t p,
                                       output coefBlock_t lev, output coefBlock_t dq,
                                       output logic anyNz);
        quantSet_t s;
        int c;
        int sl;
        longint mag;
        longint l;
        anyNz = 1'b0;
        for (int k = 0; k < 16; k++) begin
            s   = (k == 0) ? p.dc : p.ac;
            c   = int'($signed(coef[k]));
            mag = (c < 0) ? -c : c;
            l   = (mag * longint'(s.iq) + longint'(s.bias)) >>> `UV_QFIX;
            if (l > `UV_MAX_LEVEL) begin
                l = `UV_MAX_LEVEL;
            end
            if (mag <= longint'(s.zthresh)) begin
                l = 0;
            end
            sl     = (c < 0) ? -int'(l) : int'(l);
            lev[k] = 16'(sl);
            dq[k]  = 16'(sl * int'(s.q));
            anyNz  = anyNz | (l != 0);
        end
    endfunction

    function automatic longint mulCos(input longint x);
        return ((x * 20091) >>> 16) + x;
    endfunction

    function automatic longint mulSin(input longint x);
        return (x * 35468) >>> 16;
    endfunction

    function automatic logic [7:0] clipPixel(input logic [7:0] p, input longint v);
        longint s;
        s = (v >>> 3) + longint'(p);
        if (s < 0) begin
            return 8'd0;
        end
        return (s > 255) ? 8'd255 : 8'(s);
    endfunction

    function automatic pixBlock_t inverseModel(input coefBlock_t dq, input pixBlock_t p);
        longint x [16];
        longint v [16];
        longint a;
        longint b;
        longint c;
        longint d;
        pixBlock_t out;
        for (int k = 0; k < 16; k++) begin
            x[k] = longint'($signed(dq[k]));
        end
        // Columns first and then rows with rounding
        for (int col = 0; col < 4; col++) begin
            a = x[col] + x[8+col];
            b = x[col] - x[8+col];
            c = mulSin(x[4+col]) - mulCos(x[12+col]);
            d = mulCos(x[4+col]) + mulSin(x[12+col]);
            v[col]    = a + d;
            v[4+col]  = b + c;
            v[8+col]  = b - c;
            v[12+col] = a - d;
        end
        for (int r = 0; r < 4; r++) begin
            a = v[4*r] + 4 + v[4*r+2];
            b = v[4*r] + 4 - v[4*r+2];
            c = mulSin(v[4*r+1]) - mulCos(v[4*r+3]);
            d = mulCos(v[4*r+1]) + mulSin(v[4*r+3]);
            out[4*r]   = clipPixel(p[4*r], a + d);
            out[4*r+1] = clipPixel(p[4*r+1], b + c);
            out[4*r+2] = clipPixel(p[4*r+2], b - c);
            out[4*r+3] = clipPixel(p[4*r+3], a - d);
        end
        return out;
    endfunction

    // --------------------
    // Scoreboard
    // --------------------
    always @(negedge clk) begin
        expect_t    e;
        coefBlock_t coef;
        coefBlock_t lev;
        coefBlock_t dq;
        logic       anyNz;
        int         latency;
        negCycle = negCycle + 1;
        if (done === 1'b1) begin
            if (expQ.size() == 0) begin
                $display("done_o pulsed at %0t with no job in flight", $time);
                errors++;
            end else begin
                e       = expQ.pop_front();
                latency = negCycle - startCycleQ.pop_front();
                jobsChecked++;
                if (latency != `UV_LATENCY) begin
                    $display("ERROR %0t: done_o %0d cycles after start", $time, latency);
                    errors++;
                end
                if (levels !== e.levels || nz !== e.nz) begin
                    $display("ERROR %0t: levels %h nz %b, expected %h nz %b",
                             $time, levels, nz, e.levels, e.nz);
                    errors++;
                end
                if (recon !== e.recon) begin
                    $display("ERROR %0t: recon %h, expected %h", $time, recon, e.recon);
                    errors++;
                end
                if (e.quiet && (levels !== '0 || nz !== 1'b0 || recon !== e.pred)) begin
                    $display("ERROR %0t: zero residual block not passed through", $time);
                    errors++;
                end
                for (int k = 0; k < 16; k++) begin
                    if (e.clamped && levels[k] != 0 && levels[k] != 16'sd2047
                            && levels[k] != -16'sd2047) begin
                        $display("ERROR %0t: level %0d is %0d, not clamped", $time, k,
                                 $signed(levels[k]));
                        errors++;
                    end
                end
            end
        end
        if (start === 1'b1) begin
            coef = forwardModel(src, pred);
            quantModel(coef, qp, lev, dq, anyNz);
            e.levels  = lev;
            e.nz      = anyNz;
            e.recon   = inverseModel(dq, pred);
            e.pred    = pred;
            e.quiet   = markQuiet;
            e.clamped = markClamped;
            expQ.push_back(e);
            startCycleQ.push_back(negCycle);
        end
    end

    task automatic driveJob(input pixBlock_t s, input pixBlock_t p, input quantParams_t q);
        @(posedge clk);
        start <= 1'b1;
        src   <= s;
        pred  <= p;
        qp    <= q;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            start <= 1'b0;
        end
    endtask

    task automatic finishTest(input string name, input int errBefore, input int jobsBefore);
        idleCycles(1);
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        testsRun++;
        $display("%s: %0d jobs, %0d errors", name, jobsChecked - jobsBefore,
                 errors - errBefore);
    endtask

    initial begin
        int           e0;
        int           j0;
        pixBlock_t    p;
        quantParams_t q;
        rstN  = 1'b0;
        start = 1'b0;
        src   = '0;
        pred  = '0;
        qp    = '0;

        e0 = errors;
        fork
            begin
                repeat (10) @(posedge clk);
                rstN <= 1'b1;
            end
            // Quiet through reset and the first five cycles after it
            repeat (15) begin
                @(negedge clk);
                if (done !== 1'b0) begin
                    $display("ERROR %0t: done_o not low around reset", $time);
                    errors++;
                end
            end
        join
        finishTest("reset", e0, jobsChecked);

        e0 = errors;
        j0 = jobsChecked;
        markQuiet = 1'b1;
        for (int i = 0; i < NUM_ZERO; i++) begin
            p = randBlock();
            driveJob(p, p, randParams());
            idleCycles(int'(nextRand() % 2));
        end
        finishTest("zero residual", e0, j0);
        markQuiet = 1'b0;

        e0 = errors;
        j0 = jobsChecked;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            driveJob(randBlock(), randBlock(), randParams());
            idleCycles(int'(nextRand() % 3));
        end
        finishTest("random blocks", e0, j0);

        e0 = errors;
        j0 = jobsChecked;
        markQuiet = 1'b1;
        for (int i = 0; i < NUM_DEAD / 2; i++) begin
            q = randParams();
            q.dc.zthresh = '1;
            q.ac.zthresh = '1;
            driveJob(randBlock(), randBlock(), q);
        end
        idleCycles(1);
        markQuiet   = 1'b0;
        markClamped = 1'b1;
        // Huge bias pushes every nonzero coefficient past the clamp
        for (int i = 0; i < NUM_DEAD / 2; i++) begin
            q.dc = '{q: 16'(1 + nextRand() % 8), iq: 16'hffff, bias: 32'h7fff_ffff, zthresh: 0};
            q.ac = q.dc;
            driveJob(randBlock(), randBlock(), q);
        end
        finishTest("dead zone and clamp", e0, j0);
        markClamped = 1'b0;

        e0 = errors;
        j0 = jobsChecked;
        for (int i = 0; i < NUM_BURST; i++) begin
            driveJob(randBlock(), randBlock(), randParams());
            if (i >= NUM_BURST / 2) begin
                idleCycles(int'(nextRand() % 7));
            end
        end
        finishTest("back-to-back starts", e0, j0);

        if (jobsChecked != TOTAL_JOBS) begin
            $display("Only %0d of %0d jobs completed", jobsChecked, TOTAL_JOBS);
            errors++;
        end
        $display("Tests: %0d, jobs checked: %0d, errors: %0d", testsRun, jobsChecked, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/uvReconstruct_asserts.sv
// Reconstruction port assertions
`timescale 1ns/1ps
`default_nettype none

`include "uvRecon_settings.svh"

module uvReconstructAsserts (
    input wire                         clk,
    input wire                         rstN_i,
    input wire                         start_i,
    input wire                         done_i,
    input wire uvReconPkg::coefBlock_t levels_i
);

    import uvReconPkg::*;

    function automatic logic levelsInRange(input coefBlock_t lv);
        logic ok;
        ok = 1'b1;
        for (int k = 0; k < 16; k++) begin
            if ($signed(lv[k]) > `UV_MAX_LEVEL || $signed(lv[k]) < -`UV_MAX_LEVEL) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    doneKnown: assert property (@(posedge clk) disable iff (!rstN_i) !$isunknown(done_i))
        else $error("done_o is unknown");

    // One done per start after the pipeline depth
    doneLatency: assert property (@(posedge clk) disable iff (!rstN_i)
        done_i == $past(start_i, `UV_LATENCY))
        else $error("done_o does not follow start_i by the pipeline latency");

    levelRange: assert property (@(posedge clk) disable iff (!rstN_i)
        done_i |-> levelsInRange(levels_i))
        else $error("level outside the clamp range");

endmodule

bind uvReconstruct uvReconstructAsserts i_uvReconstructAsserts (
    .clk      (clk),
    .rstN_i   (rstN_i),
    .start_i  (start_i),
    .done_i   (done_o),
    .levels_i (levels_o)
);

`default_nettype wire

//--- design/uvReconstruct.sv
// Chroma block reconstruction top
`timescale 1ns/1ps
`default_nettype none

module uvReconstruct (
    input  wire                           clk,
    input  wire                           rstN_i,
    input  wire                           start_i,
    input  wire uvReconPkg::pixBlock_t    src_i,
    input  wire uvReconPkg::pixBlock_t    pred_i,
    input  wire uvReconPkg::quantParams_t qp_i,
    output logic                          done_o,
    output uvReconPkg::pixBlock_t         recon_o,
    output uvReconPkg::coefBlock_t        levels_o,
    output logic                          nz_o
);

    import uvReconPkg::*;

    logic    fwdValid;
    fwdJob_t fwdJob;
    logic    invValid;
    invJob_t invJob;

    // Residual to coefficients, two cycles
    uvForwardTransform i_uvForwardTransform (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .start_i (start_i),
        .src_i   (src_i),
        .pred_i  (pred_i),
        .qp_i    (qp_i),
        .valid_o (fwdValid),
        .job_o   (fwdJob)
    );

    uvQuantizer i_uvQuantizer (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .valid_i (fwdValid),
        .job_i   (fwdJob),
        .valid_o (invValid),
        .job_o   (invJob)
    );

    // Back to pixels, two cycles
    uvInverseTransform i_uvInverseTransform (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .valid_i  (invValid),
        .job_i    (invJob),
        .done_o   (done_o),
        .recon_o  (recon_o),
        .levels_o (levels_o),
        .nz_o     (nz_o)
    );

endmodule

`default_nettype wire

//--- design/uvInverseTransform.sv
// VP8 inverse 4x4 transform with reconstruction
`timescale 1ns/1ps
`default_nettype none

`include "uvRecon_settings.svh"

module uvInverseTransform (
    input  wire                      clk,
    input  wire                      rstN_i,
    input  wire                      valid_i,
    input  wire uvReconPkg::invJob_t job_i,
    output logic                     done_o,
    output uvReconPkg::pixBlock_t    recon_o,
    output uvReconPkg::coefBlock_t   levels_o,
    output logic                     nz_o
);

    import uvReconPkg::*;

    logic signed [31:0] vertD [16];
    logic signed [31:0] vertQ [16];
    pixBlock_t          predQ;
    coefBlock_t         levelsQ;
    logic               nzQ;
    logic               vertValidQ;
    pixBlock_t          reconD;

    // a * (1 + 20091 / 65536)
    function automatic logic signed [31:0] mul1(input logic signed [31:0] a);
        logic signed [47:0] wide;
        wide = a;
        wide = (wide * 20091) >>> 16;
        return 32'(wide) + a;
    endfunction

    // a * 35468 / 65536
    function automatic logic signed [31:0] mul2(input logic signed [31:0] a);
        logic signed [47:0] wide;
        wide = a;
        wide = (wide * 35468) >>> 16;
        return 32'(wide);
    endfunction

    function automatic logic [`UV_PIX_W-1:0] clipPix(input logic [`UV_PIX_W-1:0] p,
                                                     input logic signed [31:0] v);
        logic signed [31:0] s;
        s = v >>> 3;
        s = s + $signed({1'b0, p});
        if (s < 0) begin
            return '0;
        end else if (s > (2 ** `UV_PIX_W) - 1) begin
            return '1;
        end
        return s[`UV_PIX_W-1:0];
    endfunction

    // --------------------
    // Vertical pass
    // --------------------
    always_comb begin : vertPass
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic signed [31:0] c;
        logic signed [31:0] d;
        for (int col = 0; col < 4; col++) begin
            a = $signed(job_i.dq[col]) + $signed(job_i.dq[8+col]);
            b = $signed(job_i.dq[col]) - $signed(job_i.dq[8+col]);
            c = mul2($signed(job_i.dq[4+col])) - mul1($signed(job_i.dq[12+col]));
            d = mul1($signed(job_i.dq[4+col])) + mul2($signed(job_i.dq[12+col]));
            vertD[col]    = a + d;
            vertD[4+col]  = b + c;
            vertD[8+col]  = b - c;
            vertD[12+col] = a - d;
        end
    end

    // --------------------
    // Horizontal pass
    // --------------------
    always_comb begin : horzPass
        logic signed [31:0] dc;
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic signed [31:0] c;
        logic signed [31:0] d;
        for (int row = 0; row < 4; row++) begin
            dc = vertQ[4*row] + 4;
            a  = dc + vertQ[4*row+2];
            b  = dc - vertQ[4*row+2];
            c  = mul2(vertQ[4*row+1]) - mul1(vertQ[4*row+3]);
            d  = mul1(vertQ[4*row+1]) + mul2(vertQ[4*row+3]);
            reconD[4*row+0] = clipPix(predQ[4*row+0], a + d);
            reconD[4*row+1] = clipPix(predQ[4*row+1], b + c);
            reconD[4*row+2] = clipPix(predQ[4*row+2], b - c);
            reconD[4*row+3] = clipPix(predQ[4*row+3], a - d);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            vertValidQ <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            vertValidQ <= valid_i;
            done_o     <= vertValidQ;
        end
    end

    // Results hold until the next job lands
    always_ff @(posedge clk) begin
        if (valid_i) begin
            vertQ   <= vertD;
            predQ   <= job_i.pred;
            levelsQ <= job_i.levels;
            nzQ     <= job_i.nz;
        end
        if (vertValidQ) begin
            recon_o  <= reconD;
            levels_o <= levelsQ;
            nz_o     <= nzQ;
        end
    end

endmodule

`default_nettype wire

//--- design/uvQuantizer.sv
// Coefficient quantizer
`timescale 1ns/1ps
`default_nettype none

`include "uvRecon_settings.svh"

module uvQuantizer (
    input  wire                      clk,
    input  wire                      rstN_i,
    input  wire                      valid_i,
    input  wire uvReconPkg::fwdJob_t job_i,
    output logic                     valid_o,
    output uvReconPkg::invJob_t      job_o
);

    import uvReconPkg::*;

    invJob_t jobD;

    // --------------------
    // Level and dequant
    // --------------------
    always_comb begin : quantize
        quantSet_t          qs;
        logic signed [31:0] coef;
        logic [31:0]        absCoef;
        logic [33:0]        scaled;
        logic [31:0]        level;
        logic signed [31:0] levelS;
        logic signed [31:0] qMul;
        logic               anyNz;
        jobD.pred = job_i.pred;
        anyNz     = 1'b0;
        for (int k = 0; k < 16; k++) begin
            // DC set only for the first coefficient
            qs      = (k == 0) ? job_i.qp.dc : job_i.qp.ac;
            coef    = $signed(job_i.coef[k]);
            absCoef = (coef < 0) ? -coef : coef;
            scaled  = 34'(absCoef) * 34'(qs.iq) + 34'(qs.bias);
            level   = 32'(scaled >> `UV_QFIX);
            if (level > `UV_MAX_LEVEL) begin
                level = `UV_MAX_LEVEL;
            end
            // Dead zone
            if (absCoef <= qs.zthresh) begin
                level = '0;
            end
            levelS = (coef < 0) ? -$signed(level) : $signed(level);
            qMul   = 32'(qs.q);
            jobD.levels[k] = toCoef(levelS);
            jobD.dq[k]     = toCoef(levelS * qMul);
            anyNz          = anyNz | (level != 0);
        end
        jobD.nz = anyNz;
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            job_o <= jobD;
        end
    end

endmodule

`default_nettype wire

//--- design/uvForwardTransform.sv
// VP8 forward 4x4 transform
`timescale 1ns/1ps
`default_nettype none

module uvForwardTransform (
    input  wire                           clk,
    input  wire                           rstN_i,
    input  wire                           start_i,
    input  wire uvReconPkg::pixBlock_t    src_i,
    input  wire uvReconPkg::pixBlock_t    pred_i,
    input  wire uvReconPkg::quantParams_t qp_i,
    output logic                          valid_o,
    output uvReconPkg::fwdJob_t           job_o
);

    import uvReconPkg::*;

    fwdJob_t rowD;
    fwdJob_t rowQ;
    fwdJob_t colD;
    logic    rowValidQ;

    // --------------------
    // Row pass
    // --------------------
    always_comb begin : rowPass
        logic signed [31:0] d [4];
        logic signed [31:0] a0;
        logic signed [31:0] a1;
        logic signed [31:0] a2;
        logic signed [31:0] a3;
        rowD.pred = pred_i;
        rowD.qp   = qp_i;
        for (int r = 0; r < 4; r++) begin
            // Residual of one row
            for (int k = 0; k < 4; k++) begin
                d[k] = $signed({1'b0, src_i[4*r+k]}) - $signed({1'b0, pred_i[4*r+k]});
            end
            a0 = d[0] + d[3];
            a1 = d[1] + d[2];
            a2 = d[1] - d[2];
            a3 = d[0] - d[3];
            rowD.coef[4*r+0] = toCoef((a0 + a1) * 8);
            rowD.coef[4*r+1] = toCoef((a2 * 2217 + a3 * 5352 + 1812) >>> 9);
            rowD.coef[4*r+2] = toCoef((a0 - a1) * 8);
            rowD.coef[4*r+3] = toCoef((a3 * 2217 - a2 * 5352 + 937) >>> 9);
        end
    end

    // --------------------
    // Column pass
    // --------------------
    always_comb begin : colPass
        logic signed [31:0] t0;
        logic signed [31:0] t1;
        logic signed [31:0] t2;
        logic signed [31:0] t3;
        logic signed [31:0] a0;
        logic signed [31:0] a1;
        logic signed [31:0] a2;
        logic signed [31:0] a3;
        logic signed [31:0] bump;
        colD.pred = rowQ.pred;
        colD.qp   = rowQ.qp;
        for (int c = 0; c < 4; c++) begin
            t0 = $signed(rowQ.coef[c]);
            t1 = $signed(rowQ.coef[4+c]);
            t2 = $signed(rowQ.coef[8+c]);
            t3 = $signed(rowQ.coef[12+c]);
            a0 = t0 + t3;
            a1 = t1 + t2;
            a2 = t1 - t2;
            a3 = t0 - t3;
            // Odd row 1 rounds up on a nonzero difference
            bump = (a3 != 0) ? 32'sd1 : 32'sd0;
            colD.coef[c]    = toCoef((a0 + a1 + 7) >>> 4);
            colD.coef[4+c]  = toCoef(((a2 * 2217 + a3 * 5352 + 12000) >>> 16) + bump);
            colD.coef[8+c]  = toCoef((a0 - a1 + 7) >>> 4);
            colD.coef[12+c] = toCoef((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
        end
    end

    // --------------------
    // Pipeline registers
    // --------------------
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            rowValidQ <= 1'b0;
            valid_o   <= 1'b0;
        end else begin
            rowValidQ <= start_i;
            valid_o   <= rowValidQ;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rowQ <= rowD;
        end
        if (rowValidQ) begin
            job_o <= colD;
        end
    end

endmodule

`default_nettype wire

//--- design/uvReconPkg.sv
// Chroma reconstruction types
`default_nettype none

`include "uvRecon_settings.svh"

package uvReconPkg;

    // 16 pixels in row-major order from the top left
    typedef logic [15:0][`UV_PIX_W-1:0] pixBlock_t;

    // 16 signed coefficients in raster order
    typedef logic [15:0][`UV_COEF_W-1:0] coefBlock_t;

    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
        logic [31:0] zthresh;
    } quantSet_t;

    typedef struct packed {
        quantSet_t dc;
        quantSet_t ac;
    } quantParams_t;

    // Forward transform to quantizer
    typedef struct packed {
        coefBlock_t   coef;
        pixBlock_t    pred;
        quantParams_t qp;
    } fwdJob_t;

    // Quantizer to inverse transform
    typedef struct packed {
        coefBlock_t dq;
        coefBlock_t levels;
        pixBlock_t  pred;
        logic       nz;
    } invJob_t;

    // Truncates an intermediate to coefficient width
    function automatic logic [`UV_COEF_W-1:0] toCoef(input logic signed [31:0] v);
        return v[`UV_COEF_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- design/uvRecon_settings.svh
// Chroma reconstruction constants
`ifndef UV_RECON_SETTINGS_SVH
`define UV_RECON_SETTINGS_SVH

// Pixel width
`define UV_PIX_W      8

// Signed coefficient and level width
`define UV_COEF_W     16

// Quantizer fixed point shift
`define UV_QFIX       17

// Largest level magnitude
`define UV_MAX_LEVEL  2047

// Cycles from start to done
`define UV_LATENCY    5

`endif
